// File: common/vga_pkg.sv
`default_nettype none

package vga_pkg;

    typedef logic [31:0] word_t;
    typedef logic [7:0]  byte_t;

    // video memory, one byte per pixel
    localparam int VRAM_BYTES = 4096;
    localparam int VRAM_AW    = 12;
    localparam int VRAM_WAW   = VRAM_AW - 2;

    typedef logic [VRAM_AW-1:0] vaddr_t;

    // horizontal timing in pixels
    localparam int H_ACTIVE = 64;
    localparam int H_FRONT  = 4;
    localparam int H_SYNC   = 8;
    localparam int H_BACK   = 4;
    localparam int H_TOTAL  = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;

    // vertical timing in lines
    localparam int V_ACTIVE = 64;
    localparam int V_FRONT  = 2;
    localparam int V_SYNC   = 2;
    localparam int V_BACK   = 2;
    localparam int V_TOTAL  = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;

    typedef struct packed {
        logic         psel;
        logic         penable;
        logic         pwrite;
        logic [11:0]  paddr;
        word_t        pwdata;
        logic [3:0]   pstrb;
    } apb_req_t;

    typedef struct packed {
        logic  pready;
        word_t prdata;
        logic  pslverr;
    } apb_rsp_t;

    typedef struct packed {
        logic [VRAM_WAW-1:0] addr;
        word_t               wdata;
        logic [3:0]          wmask;
    } vram_cpu_req_t;

    typedef struct packed {
        logic  hsync;
        logic  vsync;
        logic  de;
        byte_t pixel;
    } video_out_t;

endpackage

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_video_subsys -f video_subsys.f -o sim_tb_video_subsys

./obj_dir/sim_tb_video_subsys > sim.log 2>&1
cat sim.log

if grep -q "SOME TESTS FAILED" sim.log; then
    echo "simulation failed, see sim.log"
    exit 1
fi
echo "simulation passed"

// File: tb/tb_video_subsys.sv
`timescale 1ns/100ps
`default_nettype none

module tb_video_subsys;

    localparam int APB_TIMEOUT  = 16;
    localparam int FRAME_CYCLES = vga_pkg::H_TOTAL * vga_pkg::V_TOTAL;
    localparam int NUM_WORDS    = vga_pkg::VRAM_BYTES / 4;
    localparam int NUM_PARTIAL  = 256;

    logic                cpu_clk_i;
    logic                pxl_clk_i;
    logic                arst_n_i;
    vga_pkg::apb_req_t   apb_req;
    vga_pkg::apb_rsp_t   apb_rsp;
    vga_pkg::video_out_t video;

    // what the memory should hold
    vga_pkg::byte_t shadow [0:vga_pkg::VRAM_BYTES-1];

    int err_cnt;
    int tests_run;
    int tests_failed;

    video_subsys_top u_dut (
        .cpu_clk_i (cpu_clk_i),
        .pxl_clk_i (pxl_clk_i),
        .arst_n_i  (arst_n_i),
        .apb_i     (apb_req),
        .apb_o     (apb_rsp),
        .video_o   (video)
    );

    always #20 cpu_clk_i = ~cpu_clk_i;
    always #15 pxl_clk_i = ~pxl_clk_i;

    function automatic vga_pkg::word_t expected_word(input logic [11:0] addr);
        vga_pkg::word_t w;
        for (int n = 0; n < 4; n++) begin
            w[8*n +: 8] = shadow[{addr[11:2], 2'(n)}];
        end
        return w;
    endfunction

    function automatic vga_pkg::video_out_t expected_video(input int x, input int y);
        vga_pkg::video_out_t v;
        v.hsync = !((x >= vga_pkg::H_ACTIVE + vga_pkg::H_FRONT) &&
                    (x < vga_pkg::H_ACTIVE + vga_pkg::H_FRONT + vga_pkg::H_SYNC));
        v.vsync = !((y >= vga_pkg::V_ACTIVE + vga_pkg::V_FRONT) &&
                    (y < vga_pkg::V_ACTIVE + vga_pkg::V_FRONT + vga_pkg::V_SYNC));
        v.de    = (x < vga_pkg::H_ACTIVE) && (y < vga_pkg::V_ACTIVE);
        v.pixel = v.de ? shadow[12'(y * vga_pkg::H_ACTIVE + x)] : 8'h00;
        return v;
    endfunction

    task automatic check_word(input string name, input vga_pkg::word_t got,
                              input vga_pkg::word_t exp);
        if (got !== exp) begin
            $display("FAILED %s: got %h, expected %h", name, got, exp);
            err_cnt++;
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("FAILED %s: got %h, expected %h", name, got, exp);
            err_cnt++;
        end
    endtask

    task automatic check_video(input string name, input vga_pkg::video_out_t got,
                               input vga_pkg::video_out_t exp);
        if (got !== exp) begin
            $display("FAILED %s: got %h, expected %h", name, got, exp);
            err_cnt++;
        end
    endtask

    task automatic check_run(input string what, input int len, input int exp);
        if (len != exp) begin
            $display("sync shape wrong: %s lasted %0d cycles instead of %0d", what, len, exp);
            err_cnt++;
        end
    endtask

    task automatic apb_transfer(input logic wr, input logic [11:0] addr,
                                input vga_pkg::word_t wdata, input logic [3:0] strb,
                                output vga_pkg::word_t rdata, output logic slverr);
        vga_pkg::apb_req_t req;
        int waited;
        bit done;
        req = '0;
        req.psel   = 1'b1;
        req.pwrite = wr;
        req.paddr  = addr;
        req.pwdata = wdata;
        req.pstrb  = strb;
        @(posedge cpu_clk_i);
        apb_req <= req;
        @(posedge cpu_clk_i);
        req.penable = 1'b1;
        apb_req <= req;
        waited = 0;
        done = 1'b0;
        // response is sampled mid cycle, the transfer ends on the next edge
        while (!done && waited < APB_TIMEOUT) begin
            @(negedge cpu_clk_i);
            waited++;
            done   = apb_rsp.pready;
            rdata  = apb_rsp.prdata;
            slverr = apb_rsp.pslverr;
            @(posedge cpu_clk_i);
        end
        apb_req <= '0;
        if (!done) begin
            $display("no pready within %0d cycles at address %h", APB_TIMEOUT, addr);
            err_cnt++;
        end
    endtask

    // one frame from a falling vsync to the next
    task automatic check_frame(input bit shape_only);
        vga_pkg::video_out_t prev;
        vga_pkg::video_out_t cur;
        vga_pkg::video_out_t exp;
        int waited;
        int pix_idx;
        int h_low;
        int de_run;
        int v_low;
        int lines;
        bit found;
        waited = 0;
        pix_idx = 0;
        h_low = 0;
        de_run = 0;
        v_low = 0;
        lines = 0;
        found = 1'b0;
        @(negedge pxl_clk_i);
        cur = video;
        while (!found && waited < 2 * FRAME_CYCLES) begin
            prev = cur;
            @(negedge pxl_clk_i);
            cur = video;
            waited++;
            found = prev.vsync && !cur.vsync;
        end
        if (!found) begin
            $display("vsync never fell within two frame times");
            err_cnt++;
            return;
        end
        waited = 0;
        found = 1'b0;
        while (!found && waited < FRAME_CYCLES + 16) begin
            if (!shape_only) begin
                exp = cur;
                exp.pixel = 8'h00;
                if (cur.de) begin
                    exp = expected_video(pix_idx % vga_pkg::H_ACTIVE,
                                         pix_idx / vga_pkg::H_ACTIVE);
                    pix_idx++;
                end
                check_video("video_o", cur, exp);
            end else begin
                if (!cur.hsync) begin
                    h_low++;
                end else if (h_low != 0) begin
                    check_run("hsync low", h_low, vga_pkg::H_SYNC);
                    h_low = 0;
                end
                if (cur.de) begin
                    de_run++;
                end else if (de_run != 0) begin
                    check_run("de high", de_run, vga_pkg::H_ACTIVE);
                    lines++;
                    de_run = 0;
                end
                if (!cur.vsync) begin
                    v_low++;
                end else if (v_low != 0) begin
                    check_run("vsync low", v_low, vga_pkg::V_SYNC * vga_pkg::H_TOTAL);
                    v_low = 0;
                end
            end
            prev = cur;
            @(negedge pxl_clk_i);
            cur = video;
            waited++;
            found = prev.vsync && !cur.vsync;
        end
        if (!found) begin
            $display("frame did not end with a second falling vsync");
            err_cnt++;
        end else if (!shape_only) begin
            check_run("active pixel count", pix_idx, vga_pkg::VRAM_BYTES);
        end else begin
            check_run("frame", waited, FRAME_CYCLES);
            check_run("active line count", lines, vga_pkg::V_ACTIVE);
        end
    endtask

    task automatic finish_test(input string name, input int errs_before);
        tests_run++;
        if (err_cnt == errs_before) begin
            $display("test %0d %s: pass", tests_run, name);
        end else begin
            tests_failed++;
            $display("test %0d %s: fail with %0d errors", tests_run, name,
                     err_cnt - errs_before);
        end
    endtask

    initial begin
        vga_pkg::word_t rdata;
        vga_pkg::word_t wdata;
        logic [11:0]    addr;
        logic [3:0]     strb;
        logic           slverr;
        int             errs;
        cpu_clk_i = 1'b0;
        pxl_clk_i = 1'b0;
        arst_n_i  = 1'b0;
        apb_req   = '0;
        err_cnt = 0;
        tests_run = 0;
        tests_failed = 0;
        void'($urandom(59961));
        repeat (5) @(posedge cpu_clk_i);
        arst_n_i <= 1'b1;

        errs = err_cnt;
        for (int w = 0; w < NUM_WORDS; w++) begin
            addr  = 12'(w * 4);
            wdata = $urandom();
            apb_transfer(1'b1, addr, wdata, 4'hf, rdata, slverr);
            check_bit("pslverr", slverr, 1'b0);
            for (int n = 0; n < 4; n++) begin
                shadow[addr + 12'(n)] = wdata[8*n +: 8];
            end
        end
        for (int w = 0; w < NUM_WORDS; w++) begin
            addr = 12'(w * 4);
            apb_transfer(1'b0, addr, '0, 4'h0, rdata, slverr);
            check_bit("pslverr", slverr, 1'b0);
            check_word("prdata", rdata, expected_word(addr));
        end
        finish_test("full word write and read-back", errs);

        errs = err_cnt;
        for (int i = 0; i < NUM_PARTIAL; i++) begin
            addr  = {10'($urandom()), 2'b00};
            wdata = $urandom();
            strb  = 4'($urandom());
            apb_transfer(1'b1, addr, wdata, strb, rdata, slverr);
            check_bit("pslverr", slverr, 1'b0);
            for (int n = 0; n < 4; n++) begin
                if (strb[n]) begin
                    shadow[addr + 12'(n)] = wdata[8*n +: 8];
                end
            end
            apb_transfer(1'b0, addr, '0, 4'h0, rdata, slverr);
            check_word("prdata", rdata, expected_word(addr));
        end
        finish_test("partial strobe writes", errs);

        errs = err_cnt;
        for (int n = 1; n < 4; n++) begin
            addr = {10'($urandom()), 2'(n)};
            apb_transfer(1'b1, addr, ~expected_word(addr), 4'hf, rdata, slverr);
            check_bit("pslverr", slverr, 1'b1);
            apb_transfer(1'b0, addr, '0, 4'h0, rdata, slverr);
            check_bit("pslverr", slverr, 1'b1);
            check_word("prdata", rdata, '0);
            apb_transfer(1'b0, {addr[11:2], 2'b00}, '0, 4'h0, rdata, slverr);
            check_bit("pslverr", slverr, 1'b0);
            check_word("prdata", rdata, expected_word(addr));
        end
        finish_test("misaligned access", errs);

        errs = err_cnt;
        check_frame(1'b0);
        finish_test("frame content", errs);

        errs = err_cnt;
        check_frame(1'b1);
        finish_test("sync shape", errs);

        $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, err_cnt);
        if (err_cnt == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

    // last resort if some loop never ends
    initial begin
        #5000000;
        $display("simulation did not finish within 5 ms");
        $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// File: tb/video_subsys_props.sv
`timescale 1ns/100ps
`default_nettype none

module video_subsys_props (
    input wire logic                clk_i,
    input wire logic                arst_n_i,
    input wire vga_pkg::apb_req_t   apb_req_i,
    input wire vga_pkg::apb_rsp_t   apb_rsp_i,
    input wire vga_pkg::video_out_t video_i
);

    // pready only inside an access cycle
    a_pready_in_access: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        apb_rsp_i.pready |-> (apb_req_i.psel && apb_req_i.penable))
        else $error("pready raised outside an access cycle");

    // master holds the access phase while the slave inserts wait states
    a_access_stable: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        (apb_req_i.psel && apb_req_i.penable && !apb_rsp_i.pready) |=>
        (apb_req_i.psel && apb_req_i.penable && $stable(apb_req_i.paddr) &&
         $stable(apb_req_i.pwrite) && $stable(apb_req_i.pwdata) &&
         $stable(apb_req_i.pstrb)))
        else $error("apb access phase changed before pready");

    a_de_outside_sync: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        video_i.de |-> (video_i.hsync && video_i.vsync))
        else $error("de high during a sync pulse");

    a_blank_pixel: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        !video_i.de |-> (video_i.pixel == 8'h00))
        else $error("pixel not blanked while de is low");

endmodule

bind apb_vram_bridge video_subsys_props u_props (
    .clk_i     (cpu_clk_i),
    .arst_n_i  (arst_n_i),
    .apb_req_i (apb_i),
    .apb_rsp_i (apb_o),
    .video_i   ('0)
);

bind raster_scan video_subsys_props u_props (
    .clk_i     (pxl_clk_i),
    .arst_n_i  (arst_n_i),
    .apb_req_i ('0),
    .apb_rsp_i ('0),
    .video_i   (video_o)
);

`default_nettype wire

// File: verilog/apb_vram_bridge.sv
`timescale 1ns/100ps
`default_nettype none

module apb_vram_bridge (
    input  wire logic                 cpu_clk_i,
    input  wire logic                 arst_n_i,

    input  wire vga_pkg::apb_req_t    apb_i,
    output vga_pkg::apb_rsp_t         apb_o,

    output vga_pkg::vram_cpu_req_t    vram_req_o,
    input  wire vga_pkg::word_t       vram_rdata_i
);

    typedef enum logic {
        ST_IDLE,
        ST_RD_WAIT
    } state_t;

    state_t state_r;

    logic access;
    logic misaligned;
    logic first_acc;
    logic rd_done;

    assign access     = apb_i.psel && apb_i.penable;
    assign misaligned = |apb_i.paddr[1:0];
    assign first_acc  = access && (state_r == ST_IDLE);
    assign rd_done    = access && (state_r == ST_RD_WAIT);

    // reads spend one extra access cycle waiting on the ram register
    always_ff @(posedge cpu_clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_r <= ST_IDLE;
        end else begin
            case (state_r)
                ST_IDLE: begin
                    if (first_acc && !apb_i.pwrite && !misaligned) begin
                        state_r <= ST_RD_WAIT;
                    end
                end
                ST_RD_WAIT: begin
                    if (rd_done || !apb_i.psel) begin
                        state_r <= ST_IDLE;
                    end
                end
                default: state_r <= ST_IDLE;
            endcase
        end
    end

    // address and data go straight to the ram; only the mask qualifies a write
    always_comb begin
        vram_req_o.addr  = apb_i.paddr[11:2];
        vram_req_o.wdata = apb_i.pwdata;
        vram_req_o.wmask = (first_acc && apb_i.pwrite && !misaligned) ? apb_i.pstrb : 4'b0000;
    end

    // ram output register stays put while paddr is held
    always_comb begin
        apb_o.pready  = (first_acc && (apb_i.pwrite || misaligned)) || rd_done;
        apb_o.pslverr = first_acc && misaligned;
        apb_o.prdata  = rd_done ? vram_rdata_i : '0;
    end

endmodule

`default_nettype wire

// File: verilog/video_subsys_top.sv
`timescale 1ns/100ps
`default_nettype none

module video_subsys_top (
    input  wire logic              cpu_clk_i,
    input  wire logic              pxl_clk_i,
    input  wire logic              arst_n_i,

    // cpu bus
    input  wire vga_pkg::apb_req_t apb_i,
    output vga_pkg::apb_rsp_t      apb_o,

    // pixel stream
    output vga_pkg::video_out_t    video_o
);

    vga_pkg::vram_cpu_req_t vram_req;
    vga_pkg::word_t         vram_rdata;
    vga_pkg::vaddr_t        pxl_addr;
    vga_pkg::byte_t         pxl_data;

    apb_vram_bridge u_bridge (
        .cpu_clk_i    (cpu_clk_i),
        .arst_n_i     (arst_n_i),
        .apb_i        (apb_i),
        .apb_o        (apb_o),
        .vram_req_o   (vram_req),
        .vram_rdata_i (vram_rdata)
    );

    // the only crossing between the two clock domains
    video_ram u_vram (
        .cpu_clk_i   (cpu_clk_i),
        .arst_n_i    (arst_n_i),
        .cpu_req_i   (vram_req),
        .cpu_rdata_o (vram_rdata),
        .pxl_clk_i   (pxl_clk_i),
        .pxl_addr_i  (pxl_addr),
        .pxl_data_o  (pxl_data)
    );

    raster_scan u_scan (
        .pxl_clk_i  (pxl_clk_i),
        .arst_n_i   (arst_n_i),
        .pxl_addr_o (pxl_addr),
        .pxl_data_i (pxl_data),
        .video_o    (video_o)
    );

endmodule

`default_nettype wire

// File: video/raster_scan.sv
`timescale 1ns/100ps
`default_nettype none

module raster_scan (
    input  wire logic                        pxl_clk_i,
    input  wire logic                        arst_n_i,

    // fetch port into the video ram
    output logic [vga_pkg::VRAM_AW-1:0]      pxl_addr_o,
    input  wire vga_pkg::byte_t              pxl_data_i,

    output vga_pkg::video_out_t              video_o
);

    logic [$clog2(vga_pkg::H_TOTAL)-1:0] x_cnt;
    logic [$clog2(vga_pkg::V_TOTAL)-1:0] y_cnt;

    logic hsync_c;
    logic vsync_c;
    logic de_c;

    // {hsync, vsync, de} per pipeline stage
    logic [2:0] ctl_d1;
    logic [2:0] ctl_d2;

    vga_pkg::vaddr_t addr_r;

    // x wraps every line, y every frame
    always_ff @(posedge pxl_clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            x_cnt <= '0;
            y_cnt <= '0;
        end else if (x_cnt == vga_pkg::H_TOTAL - 1) begin
            x_cnt <= '0;
            if (y_cnt == vga_pkg::V_TOTAL - 1) begin
                y_cnt <= '0;
            end else begin
                y_cnt <= y_cnt + 1'b1;
            end
        end else begin
            x_cnt <= x_cnt + 1'b1;
        end
    end

    // sync pulses sit right after the front porch
    always_comb begin
        hsync_c = !((x_cnt >= vga_pkg::H_ACTIVE + vga_pkg::H_FRONT) &&
                    (x_cnt <  vga_pkg::H_ACTIVE + vga_pkg::H_FRONT + vga_pkg::H_SYNC));
        vsync_c = !((y_cnt >= vga_pkg::V_ACTIVE + vga_pkg::V_FRONT) &&
                    (y_cnt <  vga_pkg::V_ACTIVE + vga_pkg::V_FRONT + vga_pkg::V_SYNC));
        de_c    = (x_cnt < vga_pkg::H_ACTIVE) && (y_cnt < vga_pkg::V_ACTIVE);
    end

    // linear address, only meaningful while de_c is high
    always_ff @(posedge pxl_clk_i) begin
        addr_r <= vga_pkg::vaddr_t'(y_cnt * vga_pkg::H_ACTIVE + x_cnt);
    end

    assign pxl_addr_o = addr_r;

    // match the address register plus the ram read
    always_ff @(posedge pxl_clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            ctl_d1 <= 3'b110;
            ctl_d2 <= 3'b110;
        end else begin
            ctl_d1 <= {hsync_c, vsync_c, de_c};
            ctl_d2 <= ctl_d1;
        end
    end

    always_comb begin
        video_o.hsync = ctl_d2[2];
        video_o.vsync = ctl_d2[1];
        video_o.de    = ctl_d2[0];
        // blank outside the visible area
        video_o.pixel = ctl_d2[0] ? pxl_data_i : '0;
    end

endmodule

`default_nettype wire

// File: video/video_ram.sv
`timescale 1ns/100ps
`default_nettype none

module video_ram (
    // cpu side
    input  wire logic                        cpu_clk_i,
    input  wire logic                        arst_n_i,
    input  wire vga_pkg::vram_cpu_req_t      cpu_req_i,
    output vga_pkg::word_t                   cpu_rdata_o,

    // pixel side, read only
    input  wire logic                        pxl_clk_i,
    input  wire logic [vga_pkg::VRAM_AW-1:0] pxl_addr_i,
    output vga_pkg::byte_t                   pxl_data_o
);

    vga_pkg::byte_t mem [0:vga_pkg::VRAM_BYTES-1];

    vga_pkg::word_t cpu_rdata_r;
    vga_pkg::byte_t pxl_data_r;

    // byte lanes of the addressed word, lane 0 in bits 7:0
    always_ff @(posedge cpu_clk_i) begin
        for (int n = 0; n < 4; n++) begin
            if (cpu_req_i.wmask[n]) begin
                mem[{cpu_req_i.addr, n[1:0]}] <= cpu_req_i.wdata[8*n +: 8];
            end
        end
    end

    // read before write on a shared edge
    always_ff @(posedge cpu_clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            cpu_rdata_r <= '0;
        end else begin
            for (int n = 0; n < 4; n++) begin
                cpu_rdata_r[8*n +: 8] <= mem[{cpu_req_i.addr, n[1:0]}];
            end
        end
    end

    assign cpu_rdata_o = cpu_rdata_r;

    // pixel clock domain
    always_ff @(posedge pxl_clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            pxl_data_r <= '0;
        end else begin
            pxl_data_r <= mem[pxl_addr_i];
        end
    end

    assign pxl_data_o = pxl_data_r;

endmodule

`default_nettype wire

// File: video_subsys.f
common/vga_pkg.sv
video/video_ram.sv
video/raster_scan.sv
verilog/apb_vram_bridge.sv
verilog/video_subsys_top.sv
tb/video_subsys_props.sv
tb/tb_video_subsys.sv
